/* Bender.yml */
package:
  name: decode_stage

sources:
  - verilog/isaPkg.sv
  - verilog/ctrlPkg.sv
  - verilog/fetchUnit.sv
  - verilog/ifIdReg.sv
  - verilog/decodeCtrl.sv
  - verilog/decodeStage.sv
  - target: test
    files:
      - testbench/clkGen.sv
      - testbench/decodeStageTb.sv

/* testbench/clkGen.sv */
`timescale 1ns/1ps

module clkGen (
	output logic clk,
	output logic rst
);

	// 4 ns period
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Reset held low for three rising edges
	initial begin
		rst = 1'b0;
		repeat (3) @(posedge clk);
		rst <= 1'b1;
	end

endmodule

/* testbench/decodeStageTb.sv */
`timescale 1ns/1ps

module decodeStageTb import isaPkg::*, ctrlPkg::*; ();

	localparam int testCycles    = 74;
	localparam int timeoutCycles = 5 * testCycles;

	logic clk, rst, stall, flush;
	logic [31:0] instr, rsData, rtData, pc, idPc, jrTarget;
	logic regWrite, hiLoWrite, hiLoAccess, hiLoReadSel, memWrite, memRead, dcacheEn;
	logic mulDivStart, aluShamtSel, aluSrcSel, cp0Write, cp0Read, eretFlush, isBD, exception;
	logic [1:0] npcOp, extOp, mulDivOp, hiLoWriteSel, destSel;
	logic [3:0] aluOp;
	logic [2:0] memSize, wbSel;
	logic [4:0] excCode;

	logic [31:0] mem [0:255];
	logic [31:0] expPc, expIdPc, expIdInstr;
	logic        expValid, expBD, expFetchExc, started;
	logic [18:0] row;
	logic [7:0]  side;
	logic [5:0]  expExc;
	logic [3:0]  seenExc;
	int          seed, cycles, checks, errors, testChecks, testErrors;
	string       testName;

	clkGen uClk (.clk, .rst);

	decodeStage u_dut (.*);

	// ********************
	// Program memory
	// ********************
	function automatic logic [31:0] fetchWord(input logic [31:0] addr);
		if (addr[1:0] != 2'b00 || addr[31:10] != resetVector[31:10]) begin
			return 32'd0;
		end
		return mem[addr[9:2]];
	endfunction

	assign instr = fetchWord(pc);

	function automatic logic [31:0] rW(input int rs, rt, rd, sh, input logic [5:0] fn);
		return {6'd0, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
	endfunction

	function automatic logic [31:0] iW(input logic [5:0] op, input int rs, rt, imm);
		return {op, 5'(rs), 5'(rt), 16'(imm)};
	endfunction

	// Jump to a word index of the boot region
	function automatic logic [31:0] jW(input logic [5:0] op, input int idx);
		logic [31:0] target;
		target = resetVector + 32'(idx * 4);
		return {op, target[27:2]};
	endfunction

	// ********************
	// Reference rules
	// ********************
	function automatic logic isTransfer(input logic [31:0] w);
		case (w[31:26])
			opJ, opJal, opBeq, opBne, opBlez, opBgtz: return 1'b1;
			opRegimm: return w[20:16] inside {rtBltz, rtBgez, rtBltzal, rtBgezal};
			opSpecial: return w[5:0] == fnJr || w[5:0] == fnJalr;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic [31:0] nextPcOf(input logic [31:0] w, idAddr, pcAddr, rs, rt);
		logic [31:0] link, target;
		logic        taken;
		link   = idAddr + 32'd4;
		target = link + {{14{w[15]}}, w[15:0], 2'b00};
		case (w[31:26])
			opJ, opJal: return {link[31:28], w[25:0], 2'b00};
			opSpecial:  return rs;
			opBeq:      taken = rs == rt;
			opBne:      taken = rs != rt;
			opBlez:     taken = $signed(rs) <= 0;
			opBgtz:     taken = $signed(rs) > 0;
			default:    taken = w[16] ? $signed(rs) >= 0 : $signed(rs) < 0;
		endcase
		return taken ? target : pcAddr + 32'd4;
	endfunction

	function automatic logic isKnown(input logic [31:0] w);
		case (w[31:26])
			opSpecial: return !(w[5:0] inside {6'h01, 6'h05, 6'h0a, 6'h0b, 6'h0e, 6'h0f} ||
				(w[5:0] >= 6'h14 && w[5:0] <= 6'h17) || (w[5:0] >= 6'h1c && w[5:0] <= 6'h1f) ||
				w[5:0] inside {6'h28, 6'h29} || w[5:0] >= 6'h2c);
			opRegimm: return w[20:16] inside {rtBltz, rtBgez, rtBltzal, rtBgezal};
			opCop0:   return w[25:21] == rsMfc0 || w[25:21] == rsMtc0 || w[5:0] == fnEret;
			opJ, opJal, opBeq, opBne, opBlez, opBgtz, opAddi, opAddiu, opSlti, opSltiu,
			opAndi, opOri, opXori, opLui, opLb, opLh, opLw, opLbu, opLhu, opSb, opSh, opSw:
				return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// Top bit says an exception is due, the rest is its code
	function automatic logic [5:0] excOf(input logic [31:0] w, input logic badFetch);
		if (badFetch) return {1'b1, excAdel};
		if (!isKnown(w)) return {1'b1, excRi};
		if (w[31:26] == opSpecial && w[5:0] == fnBreak) return {1'b1, excBp};
		if (w[31:26] == opSpecial && w[5:0] == fnSyscall) return {1'b1, excSys};
		return 6'd0;
	endfunction

	function automatic logic [18:0] rowOf(input logic rw, mw, mr, input logic [3:0] alu,
			input logic [1:0] ext, input logic [2:0] wb, input logic [1:0] dest,
			input logic hlw, mds, c0w, c0r);
		return {1'b1, rw, mw, mr, alu, ext, wb, dest, hlw, mds, c0w, c0r};
	endfunction

	// Expected fields by opcode and funct, top bit marks a table entry
	function automatic logic [18:0] tableOf(input logic [31:0] w);
		case (w[31:26])
			opSpecial: case (w[5:0])
				fnAddu: return rowOf(1, 0, 0, aluAddu, extZero, wbAlu, destRd, 0, 0, 0, 0);
				fnSll:  return rowOf(1, 0, 0, aluSll, extZero, wbAlu, destRd, 0, 0, 0, 0);
				fnMult, fnDivu:
					return rowOf(0, 0, 0, aluNone, extZero, wbHiLo, destRd, 1, 1, 0, 0);
				fnMfhi: return rowOf(1, 0, 0, aluNone, extZero, wbHiLo, destRd, 0, 0, 0, 0);
				fnMtlo: return rowOf(0, 0, 0, aluNone, extZero, wbAlu, destRd, 1, 0, 0, 0);
				default: return 19'd0;
			endcase
			opAddi: return rowOf(1, 0, 0, aluAdd, extSign, wbAlu, destRt, 0, 0, 0, 0);
			opOri:  return rowOf(1, 0, 0, aluOr, extZero, wbAlu, destRt, 0, 0, 0, 0);
			opLui:  return rowOf(1, 0, 0, aluNone, extUpper, wbUpper, destRt, 0, 0, 0, 0);
			opLw, opLbu: return rowOf(1, 0, 1, aluAdd, extSign, wbMem, destRt, 0, 0, 0, 0);
			opSh, opSw:  return rowOf(0, 1, 0, aluAdd, extSign, wbAlu, destRt, 0, 0, 0, 0);
			opCop0: return (w[25:21] == rsMfc0) ?
				rowOf(1, 0, 0, aluNone, extZero, wbCp0, destRt, 0, 0, 0, 1) :
				rowOf(0, 0, 0, aluNone, extZero, wbAlu, destRt, 0, 0, 1, 0);
			default: return 19'd0;
		endcase
	endfunction

	// HI/LO access, HI read, shift by shamt, immediate operand, mul/div op, HI/LO write source
	function automatic logic [7:0] sideOf(input logic [31:0] w);
		if (w[31:26] != opSpecial) begin
			return 8'b0001_0000;
		end
		case (w[5:0])
			fnSll:   return 8'b0010_0000;
			fnMult:  return {4'b1000, mdMult, hlwMulDiv};
			fnDivu:  return {4'b1000, mdDivu, hlwMulDiv};
			fnMfhi:  return 8'b1100_0000;
			fnMtlo:  return {4'b1000, 2'b00, hlwMtlo};
			default: return 8'b0000_0000;
		endcase
	endfunction

	function automatic logic [2:0] sizeOf(input logic [5:0] op);
		case (op)
			opLw:    return memLw;
			opLbu:   return memLbu;
			opSh:    return memSh;
			default: return memSw;
		endcase
	endfunction

	// Operands near zero hit equal, negative, zero and positive often
	function automatic logic [31:0] smallRandom();
		return $random(seed) % 3;
	endfunction

	// ********************
	// Expected pipeline state
	// ********************
	always @(posedge clk) begin
		started <= 1'b1;
		cycles  <= cycles + 1;
		if (!rst) begin
			expPc       <= resetVector;
			expValid    <= 1'b0;
			expBD       <= 1'b0;
			expFetchExc <= 1'b0;
		end else if (flush) begin
			expPc       <= excVector;
			expValid    <= 1'b0;
			expBD       <= 1'b0;
			expFetchExc <= 1'b0;
		end else if (!stall) begin
			expPc <= (expValid && isTransfer(expIdInstr)) ?
				nextPcOf(expIdInstr, expIdPc, expPc, rsData, rtData) : expPc + 32'd4;
			expIdPc     <= expPc;
			expIdInstr  <= fetchWord(expPc);
			expValid    <= 1'b1;
			expBD       <= expValid && isTransfer(expIdInstr);
			expFetchExc <= expPc[1:0] != 2'b00;
		end
	end

	always @(posedge clk) begin
		if (cycles >= timeoutCycles) begin
			$display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
			$display("Testbench failed");
			$finish;
		end
	end

	task automatic expectEq(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("** Error: %s = %h, expected %h (pc %h)", name, got, exp, expPc);
		end
	endtask

	// Outputs settle well before the falling edge
	always @(negedge clk) begin
		if (started) begin
			expectEq("pc", pc, expPc);
			if (!expValid) begin
				expectEq("regWrite", regWrite, 0);
				expectEq("memWrite", memWrite, 0);
				expectEq("memRead", memRead, 0);
				expectEq("hiLoWrite", hiLoWrite, 0);
				expectEq("mulDivStart", mulDivStart, 0);
				expectEq("dcacheEn", dcacheEn, 0);
				expectEq("cp0Write", cp0Write, 0);
				expectEq("eretFlush", eretFlush, 0);
				expectEq("exception", exception, 0);
				expectEq("npcOp", npcOp, npcSeq);
			end else begin
				expectEq("idPc", idPc, expIdPc);
				expectEq("isBD", isBD, expBD);
				expExc = excOf(expIdInstr, expFetchExc);
				expectEq("exception", exception, expExc[5]);
				if (expExc[5]) begin
					expectEq("excCode", excCode, expExc[4:0]);
					seenExc[0] |= excCode == excAdel;
					seenExc[1] |= excCode == excRi;
					seenExc[2] |= excCode == excBp;
					seenExc[3] |= excCode == excSys;
				end
				row = tableOf(expIdInstr);
				if (row[18] && !expFetchExc) begin
					expectEq("regWrite", regWrite, row[17]);
					expectEq("memWrite", memWrite, row[16]);
					expectEq("memRead", memRead, row[15]);
					expectEq("aluOp", aluOp, row[14:11]);
					expectEq("extOp", extOp, row[10:9]);
					expectEq("wbSel", wbSel, row[8:6]);
					expectEq("destSel", destSel, row[5:4]);
					expectEq("hiLoWrite", hiLoWrite, row[3]);
					expectEq("mulDivStart", mulDivStart, row[2]);
					expectEq("cp0Write", cp0Write, row[1]);
					expectEq("cp0Read", cp0Read, row[0]);
					if (row[16] || row[15]) begin
						expectEq("memSize", memSize, sizeOf(expIdInstr[31:26]));
					end
					side = sideOf(expIdInstr);
					expectEq("hiLoAccess", hiLoAccess, side[7]);
					expectEq("aluShamtSel", aluShamtSel, side[5]);
					if (row[14:11] != aluNone) begin
						expectEq("aluSrcSel", aluSrcSel, side[4]);
					end
					if (side[7] && !row[3]) begin
						expectEq("hiLoReadSel", hiLoReadSel, side[6]);
					end
					if (row[2]) begin
						expectEq("mulDivOp", mulDivOp, side[3:2]);
					end
					if (row[3]) begin
						expectEq("hiLoWriteSel", hiLoWriteSel, side[1:0]);
					end
				end
			end
		end
	end

	// ********************
	// Stimulus
	// ********************
	task automatic runCycles(input int n);
		repeat (n) begin
			@(posedge clk);
			// Word at the old PC enters ID on this edge
			if (fetchWord(expPc) == rW(9, 0, 0, 0, fnJr)) begin
				rsData <= jrTarget;
			end else begin
				rsData <= smallRandom();
			end
			rtData <= smallRandom();
		end
	endtask

	task automatic startTest(input string name);
		testName   = name;
		testChecks = checks;
		testErrors = errors;
	endtask

	task automatic endTest();
		$display("%-12s done, %0d checks, %0d errors", testName,
			checks - testChecks, errors - testErrors);
	endtask

	initial begin
		seed     = 92;
		cycles   = 0;
		checks   = 0;
		errors   = 0;
		started  = 1'b0;
		seenExc  = 4'd0;
		stall    = 1'b0;
		flush    = 1'b0;
		rsData   = 32'd0;
		rtData   = 32'd0;
		jrTarget = resetVector + 32'h102;
		for (int i = 0; i < 256; i++) begin
			mem[i] = 32'd0;
		end
		mem[0]  = rW(1, 2, 3, 0, fnAddu);
		mem[1]  = rW(0, 2, 3, 4, fnSll);
		mem[2]  = iW(opAddi, 1, 4, -1);
		mem[3]  = iW(opOri, 1, 5, 'hff);
		mem[4]  = iW(opLui, 0, 6, 'h1234);
		mem[5]  = iW(opLw, 1, 7, 8);
		mem[6]  = iW(opLbu, 1, 7, 3);
		mem[7]  = iW(opSh, 1, 7, 2);
		mem[8]  = iW(opSw, 1, 7, 4);
		mem[9]  = rW(1, 2, 0, 0, fnMult);
		mem[10] = rW(1, 2, 0, 0, fnDivu);
		mem[11] = rW(0, 0, 3, 0, fnMfhi);
		mem[12] = rW(1, 0, 0, 0, fnMtlo);
		mem[13] = {opCop0, rsMfc0, 5'd8, 5'd12, 11'd0};
		mem[14] = {opCop0, rsMtc0, 5'd8, 5'd14, 11'd0};
		mem[15] = iW(opBeq, 1, 2, 2);
		mem[18] = iW(opBne, 1, 2, 1);
		mem[20] = iW(opBlez, 1, 0, 1);
		mem[22] = iW(opBgtz, 1, 0, 1);
		mem[24] = iW(opRegimm, 1, rtBgez, 1);
		mem[26] = jW(opJ, 30);
		mem[27] = rW(1, 2, 3, 0, fnAddu);
		mem[30] = jW(opJal, 34);
		mem[34] = rW(9, 0, 0, 0, fnJr);
		// Exception handler region
		mem[224] = rW(0, 0, 0, 0, fnBreak);
		mem[225] = rW(0, 0, 0, 0, fnSyscall);
		mem[226] = 32'hFC000000;
		mem[227] = rW(1, 2, 3, 0, 6'h3f);
		mem[228] = rW(0, 0, 3, 0, fnMfhi);

		startTest("reset");
		repeat (3) @(posedge clk);
		runCycles(2);
		endTest();

		startTest("decode");
		runCycles(16);
		endTest();

		startTest("branches");
		runCycles(32);
		endTest();

		startTest("exceptions");
		flush <= 1'b1;
		runCycles(1);
		flush <= 1'b0;
		runCycles(12);
		if (seenExc != 4'b1111) begin
			errors++;
			$display("Not every exception code was raised, seen mask %b", seenExc);
		end
		endTest();

		startTest("stall");
		stall <= 1'b1;
		runCycles(3);
		stall <= 1'b0;
		runCycles(4);
		endTest();

		$display("Total: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* verilog/ctrlPkg.sv */
package ctrlPkg;

	// ********************
	// ALU operations
	// ********************
	localparam logic [3:0] aluAdd  = 4'b0000;
	localparam logic [3:0] aluSub  = 4'b0001;
	localparam logic [3:0] aluOr   = 4'b0010;
	localparam logic [3:0] aluAnd  = 4'b0011;
	localparam logic [3:0] aluNor  = 4'b0100;
	localparam logic [3:0] aluXor  = 4'b0101;
	localparam logic [3:0] aluSll  = 4'b0110;
	localparam logic [3:0] aluSrl  = 4'b0111;
	localparam logic [3:0] aluSra  = 4'b1000;
	localparam logic [3:0] aluSlt  = 4'b1001;
	localparam logic [3:0] aluSltu = 4'b1010;
	localparam logic [3:0] aluAddu = 4'b1011;
	localparam logic [3:0] aluSubu = 4'b1100;
	localparam logic [3:0] aluNone = 4'b1111;

	// Multiply/divide unit
	localparam logic [1:0] mdMultu = 2'b00;
	localparam logic [1:0] mdMult  = 2'b01;
	localparam logic [1:0] mdDivu  = 2'b10;
	localparam logic [1:0] mdDiv   = 2'b11;

	// ********************
	// Next PC source
	// ********************
	localparam logic [1:0] npcSeq    = 2'b00;
	localparam logic [1:0] npcBranch = 2'b01;
	localparam logic [1:0] npcJump   = 2'b10;
	localparam logic [1:0] npcReg    = 2'b11;

	// Immediate extension
	localparam logic [1:0] extZero  = 2'b00;
	localparam logic [1:0] extSign  = 2'b01;
	localparam logic [1:0] extUpper = 2'b10;

	// Data memory access size, load variants carry the sign mode
	localparam logic [2:0] memSb  = 3'b000;
	localparam logic [2:0] memSh  = 3'b001;
	localparam logic [2:0] memSw  = 3'b010;
	localparam logic [2:0] memLbu = 3'b011;
	localparam logic [2:0] memLb  = 3'b100;
	localparam logic [2:0] memLhu = 3'b101;
	localparam logic [2:0] memLh  = 3'b110;
	localparam logic [2:0] memLw  = 3'b111;

	// ********************
	// Writeback muxes
	// ********************
	localparam logic [1:0] destRt  = 2'b00;
	localparam logic [1:0] destRd  = 2'b01;
	localparam logic [1:0] destR31 = 2'b10;

	localparam logic [2:0] wbHiLo  = 3'b000;
	localparam logic [2:0] wbUpper = 3'b001;
	localparam logic [2:0] wbAlu   = 3'b010;
	localparam logic [2:0] wbLink  = 3'b011;
	localparam logic [2:0] wbMem   = 3'b100;
	localparam logic [2:0] wbCp0   = 3'b101;

	localparam logic [1:0] hlwMtlo   = 2'b00;
	localparam logic [1:0] hlwMthi   = 2'b01;
	localparam logic [1:0] hlwMulDiv = 2'b10;

	// CP0 Cause.ExcCode values
	localparam logic [4:0] excAdel = 5'd4;
	localparam logic [4:0] excSys  = 5'd8;
	localparam logic [4:0] excBp   = 5'd9;
	localparam logic [4:0] excRi   = 5'd10;

	// Sign class of rs for the single-operand branches
	localparam logic [1:0] cmpZero = 2'b00;
	localparam logic [1:0] cmpPos  = 2'b01;
	localparam logic [1:0] cmpNeg  = 2'b10;

endpackage

/* verilog/decodeCtrl.sv */
`timescale 1ns/1ps

module decodeCtrl import isaPkg::*, ctrlPkg::*; (
	input  instrWord    idInstr,
	input  logic        idValid,
	input  logic        idFetchExc,
	input  logic        idInDelaySlot,
	input  logic [31:0] rsData,
	input  logic [31:0] rtData,
	output logic        regWrite,
	output logic        hiLoWrite,
	output logic        hiLoAccess,
	output logic        hiLoReadSel,
	output logic        memWrite,
	output logic        memRead,
	output logic        dcacheEn,
	output logic        mulDivStart,
	output logic        aluShamtSel,
	output logic        aluSrcSel,
	output logic        cp0Write,
	output logic        cp0Read,
	output logic        eretFlush,
	output logic        isBranch,
	output logic        isBD,
	output logic        exception,
	output logic [1:0]  npcOp,
	output logic [1:0]  extOp,
	output logic [3:0]  aluOp,
	output logic [1:0]  mulDivOp,
	output logic [1:0]  hiLoWriteSel,
	output logic [2:0]  memSize,
	output logic [1:0]  destSel,
	output logic [2:0]  wbSel,
	output logic [4:0]  excCode
);

	logic [5:0] op;
	logic [5:0] funct;
	logic [4:0] rs;
	logic [4:0] rt;
	logic       rsEqRt;
	logic [1:0] rsClass;
	logic       known;

	assign op    = idInstr.rType.op;
	assign funct = idInstr.rType.funct;
	assign rs    = idInstr.rType.rs;
	assign rt    = idInstr.rType.rt;

	// Branch comparator
	assign rsEqRt  = (rsData == rtData);
	assign rsClass = rsData[31] ? cmpNeg : ((rsData == 32'd0) ? cmpZero : cmpPos);

	function automatic logic [3:0] rTypeAlu(input logic [5:0] fn);
		case (fn)
			fnAdd:          return aluAdd;
			fnAddu:         return aluAddu;
			fnSub:          return aluSub;
			fnSubu:         return aluSubu;
			fnOr:           return aluOr;
			fnAnd:          return aluAnd;
			fnNor:          return aluNor;
			fnXor:          return aluXor;
			fnSll, fnSllv:  return aluSll;
			fnSrl, fnSrlv:  return aluSrl;
			fnSra, fnSrav:  return aluSra;
			fnSlt:          return aluSlt;
			fnSltu:         return aluSltu;
			default:        return aluNone;
		endcase
	endfunction

	function automatic logic [2:0] memSizeOf(input logic [5:0] opc);
		case (opc)
			opSb:    return memSb;
			opSh:    return memSh;
			opSw:    return memSw;
			opLbu:   return memLbu;
			opLb:    return memLb;
			opLhu:   return memLhu;
			opLh:    return memLh;
			default: return memLw;
		endcase
	endfunction

	always_comb begin
		regWrite     = 1'b0;
		hiLoWrite    = 1'b0;
		hiLoAccess   = 1'b0;
		hiLoReadSel  = 1'b0;
		memWrite     = 1'b0;
		memRead      = 1'b0;
		dcacheEn     = 1'b0;
		mulDivStart  = 1'b0;
		aluShamtSel  = 1'b0;
		aluSrcSel    = 1'b1;
		cp0Write     = 1'b0;
		cp0Read      = 1'b0;
		eretFlush    = 1'b0;
		isBranch     = 1'b0;
		isBD         = idInDelaySlot;
		exception    = 1'b0;
		npcOp        = npcSeq;
		extOp        = extZero;
		aluOp        = aluNone;
		mulDivOp     = mdMultu;
		hiLoWriteSel = hlwMtlo;
		memSize      = memSizeOf(op);
		destSel      = destRt;
		wbSel        = wbAlu;
		excCode      = 5'd0;
		known        = 1'b1;

		// ********************
		// Main decode
		// ********************
		case (op)
			opSpecial: begin
				destSel   = destRd;
				aluSrcSel = 1'b0;
				case (funct)
					fnAdd, fnAddu, fnSub, fnSubu, fnOr, fnAnd, fnNor, fnXor,
					fnSll, fnSllv, fnSrl, fnSrlv, fnSra, fnSrav, fnSlt, fnSltu: begin
						regWrite    = 1'b1;
						aluOp       = rTypeAlu(funct);
						aluShamtSel = (funct == fnSll) || (funct == fnSrl) || (funct == fnSra);
					end
					fnJr: begin
						isBranch = 1'b1;
						npcOp    = npcReg;
					end
					fnJalr: begin
						isBranch = 1'b1;
						npcOp    = npcReg;
						regWrite = 1'b1;
						wbSel    = wbLink;
					end
					fnMfhi, fnMflo: begin
						regWrite    = 1'b1;
						hiLoAccess  = 1'b1;
						hiLoReadSel = (funct == fnMfhi);
						wbSel       = wbHiLo;
					end
					fnMthi, fnMtlo: begin
						hiLoWrite    = 1'b1;
						hiLoAccess   = 1'b1;
						hiLoWriteSel = (funct == fnMthi) ? hlwMthi : hlwMtlo;
					end
					fnMult, fnMultu, fnDiv, fnDivu: begin
						hiLoWrite    = 1'b1;
						hiLoAccess   = 1'b1;
						mulDivStart  = 1'b1;
						hiLoWriteSel = hlwMulDiv;
						wbSel        = wbHiLo;
						case (funct)
							fnMult:  mulDivOp = mdMult;
							fnDiv:   mulDivOp = mdDiv;
							fnDivu:  mulDivOp = mdDivu;
							default: mulDivOp = mdMultu;
						endcase
					end
					fnSyscall, fnBreak: ;
					default: known = 1'b0;
				endcase
			end
			opAddi, opAddiu, opSlti, opSltiu: begin
				regWrite = 1'b1;
				extOp    = extSign;
				case (op)
					opAddi:  aluOp = aluAdd;
					opAddiu: aluOp = aluAddu;
					opSlti:  aluOp = aluSlt;
					default: aluOp = aluSltu;
				endcase
			end
			opAndi, opOri, opXori: begin
				regWrite = 1'b1;
				case (op)
					opAndi:  aluOp = aluAnd;
					opOri:   aluOp = aluOr;
					default: aluOp = aluXor;
				endcase
			end
			opLui: begin
				regWrite = 1'b1;
				extOp    = extUpper;
				wbSel    = wbUpper;
			end
			opLb, opLbu, opLh, opLhu, opLw: begin
				regWrite = 1'b1;
				memRead  = 1'b1;
				dcacheEn = 1'b1;
				aluOp    = aluAdd;
				extOp    = extSign;
				wbSel    = wbMem;
			end
			opSb, opSh, opSw: begin
				memWrite = 1'b1;
				dcacheEn = 1'b1;
				aluOp    = aluAdd;
				extOp    = extSign;
			end

			// Conditional branches resolve here in ID
			opBeq, opBne, opBlez, opBgtz: begin
				isBranch = 1'b1;
				if ((op == opBeq && rsEqRt) || (op == opBne && !rsEqRt) ||
						(op == opBlez && rsClass != cmpPos) ||
						(op == opBgtz && rsClass == cmpPos)) begin
					npcOp = npcBranch;
				end
			end
			opRegimm: begin
				destSel = destR31;
				wbSel   = wbLink;
				case (rt)
					rtBltz, rtBgez, rtBltzal, rtBgezal: begin
						isBranch = 1'b1;
						// Link variants write r31 whether taken or not
						regWrite = rt[4];
						if ((rsClass == cmpNeg) != rt[0]) begin
							npcOp = npcBranch;
						end
					end
					default: known = 1'b0;
				endcase
			end
			opJ, opJal: begin
				isBranch = 1'b1;
				npcOp    = npcJump;
				if (op == opJal) begin
					regWrite = 1'b1;
					destSel  = destR31;
					wbSel    = wbLink;
				end
			end
			opCop0: begin
				if (rs == rsMfc0) begin
					regWrite = 1'b1;
					cp0Read  = 1'b1;
					wbSel    = wbCp0;
				end else if (rs == rsMtc0) begin
					cp0Write = 1'b1;
				end else if (funct == fnEret) begin
					eretFlush = 1'b1;
				end else begin
					known = 1'b0;
				end
			end
			default: known = 1'b0;
		endcase

		// ********************
		// Exception priority
		// ********************
		if (idFetchExc) begin
			exception = 1'b1;
			excCode   = excAdel;
		end else if (!known) begin
			exception = 1'b1;
			excCode   = excRi;
		end else if (op == opSpecial && funct == fnBreak) begin
			exception = 1'b1;
			excCode   = excBp;
		end else if (op == opSpecial && funct == fnSyscall) begin
			exception = 1'b1;
			excCode   = excSys;
		end

		// Bubble in ID has no side effects
		if (!idValid) begin
			regWrite    = 1'b0;
			hiLoWrite   = 1'b0;
			hiLoAccess  = 1'b0;
			memWrite    = 1'b0;
			memRead     = 1'b0;
			dcacheEn    = 1'b0;
			mulDivStart = 1'b0;
			cp0Write    = 1'b0;
			cp0Read     = 1'b0;
			eretFlush   = 1'b0;
			isBranch    = 1'b0;
			isBD        = 1'b0;
			exception   = 1'b0;
			excCode     = 5'd0;
			npcOp       = npcSeq;
		end
	end

endmodule

/* verilog/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage import isaPkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        stall,
	input  logic        flush,
	input  instrWord    instr,
	input  logic [31:0] rsData,
	input  logic [31:0] rtData,
	output logic [31:0] pc,
	output logic [31:0] idPc,
	output logic        regWrite,
	output logic        hiLoWrite,
	output logic        hiLoAccess,
	output logic        hiLoReadSel,
	output logic        memWrite,
	output logic        memRead,
	output logic        dcacheEn,
	output logic        mulDivStart,
	output logic        aluShamtSel,
	output logic        aluSrcSel,
	output logic        cp0Write,
	output logic        cp0Read,
	output logic        eretFlush,
	output logic        isBD,
	output logic        exception,
	output logic [1:0]  npcOp,
	output logic [1:0]  extOp,
	output logic [3:0]  aluOp,
	output logic [1:0]  mulDivOp,
	output logic [1:0]  hiLoWriteSel,
	output logic [2:0]  memSize,
	output logic [1:0]  destSel,
	output logic [2:0]  wbSel,
	output logic [4:0]  excCode
);

	logic     fetchExc;
	logic     isBranch;
	instrWord idInstr;
	logic     idValid;
	logic     idFetchExc;
	logic     idInDelaySlot;

	// IF
	fetchUnit uFetch (
		.clk, .rst, .stall, .flush, .npcOp, .idPc, .idInstr, .rsData,
		.pc, .fetchExc
	);

	// IF/ID
	ifIdReg uIfId (
		.clk, .rst, .stall, .flush, .pc, .instr, .fetchExc, .isBranch,
		.idPc, .idInstr, .idValid, .idFetchExc, .idInDelaySlot
	);

	// ID, feeds npcOp back to fetch in the same cycle
	decodeCtrl uDecode (
		.idInstr, .idValid, .idFetchExc, .idInDelaySlot, .rsData, .rtData,
		.regWrite, .hiLoWrite, .hiLoAccess, .hiLoReadSel, .memWrite, .memRead,
		.dcacheEn, .mulDivStart, .aluShamtSel, .aluSrcSel, .cp0Write, .cp0Read,
		.eretFlush, .isBranch, .isBD, .exception, .npcOp, .extOp, .aluOp,
		.mulDivOp, .hiLoWriteSel, .memSize, .destSel, .wbSel, .excCode
	);

endmodule

/* verilog/fetchUnit.sv */
`timescale 1ns/1ps

module fetchUnit import isaPkg::*, ctrlPkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        stall,
	input  logic        flush,
	input  logic [1:0]  npcOp,
	input  logic [31:0] idPc,
	input  instrWord    idInstr,
	input  logic [31:0] rsData,
	output logic [31:0] pc,
	output logic        fetchExc
);

	logic [31:0] seqPc;
	logic [31:0] idPcPlus4;
	logic [31:0] branchTarget;
	logic [31:0] jumpTarget;
	logic [31:0] nextPc;

	assign seqPc     = pc + 32'd4;
	assign idPcPlus4 = idPc + 32'd4;

	// Offset is relative to the delay slot address
	assign branchTarget = idPcPlus4 +
		{{14{idInstr.iType.imm[15]}}, idInstr.iType.imm, 2'b00};

	// Stays inside the 256 MB region of the delay slot
	assign jumpTarget = {idPcPlus4[31:28], idInstr.jType.index, 2'b00};

	always_comb begin
		case (npcOp)
			npcBranch: nextPc = branchTarget;
			npcJump:   nextPc = jumpTarget;
			npcReg:    nextPc = rsData;
			default:   nextPc = seqPc;
		endcase
	end

	// Exception redirect has priority over a held pipeline
	always_ff @(posedge clk) begin
		if (!rst) begin
			pc <= resetVector;
		end else if (flush) begin
			pc <= excVector;
		end else if (!stall) begin
			pc <= nextPc;
		end
	end

	// Only jr/jalr can produce an unaligned PC
	assign fetchExc = (pc[1:0] != 2'b00);

endmodule

/* verilog/ifIdReg.sv */
`timescale 1ns/1ps

module ifIdReg import isaPkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        stall,
	input  logic        flush,
	input  logic [31:0] pc,
	input  instrWord    instr,
	input  logic        fetchExc,
	input  logic        isBranch,
	output logic [31:0] idPc,
	output instrWord    idInstr,
	output logic        idValid,
	output logic        idFetchExc,
	output logic        idInDelaySlot
);

	// Control bits, flush turns the slot into a bubble
	always_ff @(posedge clk) begin
		if (!rst || flush) begin
			idValid       <= 1'b0;
			idFetchExc    <= 1'b0;
			idInDelaySlot <= 1'b0;
		end else if (!stall) begin
			idValid       <= 1'b1;
			idFetchExc    <= fetchExc;
			idInDelaySlot <= isBranch;
		end
	end

	// Payload
	always_ff @(posedge clk) begin
		if (!stall) begin
			idPc    <= pc;
			idInstr <= instr;
		end
	end

endmodule

/* verilog/isaPkg.sv */
package isaPkg;

	// ********************
	// Instruction formats
	// ********************
	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rTypeFmt;

	typedef struct packed {
		logic [5:0]  op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} iTypeFmt;

	typedef struct packed {
		logic [5:0]  op;
		logic [25:0] index;
	} jTypeFmt;

	// Same 32-bit word, three ways to read it
	typedef union packed {
		rTypeFmt rType;
		iTypeFmt iType;
		jTypeFmt jType;
	} instrWord;

	// ********************
	// Opcodes
	// ********************
	localparam logic [5:0] opSpecial = 6'b000000;
	localparam logic [5:0] opRegimm  = 6'b000001;
	localparam logic [5:0] opJ       = 6'b000010;
	localparam logic [5:0] opJal     = 6'b000011;
	localparam logic [5:0] opBeq     = 6'b000100;
	localparam logic [5:0] opBne     = 6'b000101;
	localparam logic [5:0] opBlez    = 6'b000110;
	localparam logic [5:0] opBgtz    = 6'b000111;
	localparam logic [5:0] opAddi    = 6'b001000;
	localparam logic [5:0] opAddiu   = 6'b001001;
	localparam logic [5:0] opSlti    = 6'b001010;
	localparam logic [5:0] opSltiu   = 6'b001011;
	localparam logic [5:0] opAndi    = 6'b001100;
	localparam logic [5:0] opOri     = 6'b001101;
	localparam logic [5:0] opXori    = 6'b001110;
	localparam logic [5:0] opLui     = 6'b001111;
	localparam logic [5:0] opCop0    = 6'b010000;
	localparam logic [5:0] opLb      = 6'b100000;
	localparam logic [5:0] opLh      = 6'b100001;
	localparam logic [5:0] opLw      = 6'b100011;
	localparam logic [5:0] opLbu     = 6'b100100;
	localparam logic [5:0] opLhu     = 6'b100101;
	localparam logic [5:0] opSb      = 6'b101000;
	localparam logic [5:0] opSh      = 6'b101001;
	localparam logic [5:0] opSw      = 6'b101011;

	// ********************
	// SPECIAL funct codes
	// ********************
	localparam logic [5:0] fnSll     = 6'b000000;
	localparam logic [5:0] fnSrl     = 6'b000010;
	localparam logic [5:0] fnSra     = 6'b000011;
	localparam logic [5:0] fnSllv    = 6'b000100;
	localparam logic [5:0] fnSrlv    = 6'b000110;
	localparam logic [5:0] fnSrav    = 6'b000111;
	localparam logic [5:0] fnJr      = 6'b001000;
	localparam logic [5:0] fnJalr    = 6'b001001;
	localparam logic [5:0] fnSyscall = 6'b001100;
	localparam logic [5:0] fnBreak   = 6'b001101;
	localparam logic [5:0] fnMfhi    = 6'b010000;
	localparam logic [5:0] fnMthi    = 6'b010001;
	localparam logic [5:0] fnMflo    = 6'b010010;
	localparam logic [5:0] fnMtlo    = 6'b010011;
	localparam logic [5:0] fnMult    = 6'b011000;
	localparam logic [5:0] fnMultu   = 6'b011001;
	localparam logic [5:0] fnDiv     = 6'b011010;
	localparam logic [5:0] fnDivu    = 6'b011011;
	localparam logic [5:0] fnAdd     = 6'b100000;
	localparam logic [5:0] fnAddu    = 6'b100001;
	localparam logic [5:0] fnSub     = 6'b100010;
	localparam logic [5:0] fnSubu    = 6'b100011;
	localparam logic [5:0] fnAnd     = 6'b100100;
	localparam logic [5:0] fnOr      = 6'b100101;
	localparam logic [5:0] fnXor     = 6'b100110;
	localparam logic [5:0] fnNor     = 6'b100111;
	localparam logic [5:0] fnSlt     = 6'b101010;
	localparam logic [5:0] fnSltu    = 6'b101011;

	// REGIMM rt codes and COP0 rs codes
	localparam logic [4:0] rtBltz   = 5'b00000;
	localparam logic [4:0] rtBgez   = 5'b00001;
	localparam logic [4:0] rtBltzal = 5'b10000;
	localparam logic [4:0] rtBgezal = 5'b10001;
	localparam logic [4:0] rsMfc0   = 5'b00000;
	localparam logic [4:0] rsMtc0   = 5'b00100;
	localparam logic [5:0] fnEret   = 6'b011000;

	// Boot ROM entry and general exception entry
	localparam logic [31:0] resetVector = 32'hBFC00000;
	localparam logic [31:0] excVector   = 32'hBFC00380;

endpackage

/* vlog.f */
verilog/isaPkg.sv
verilog/ctrlPkg.sv
verilog/fetchUnit.sv
verilog/ifIdReg.sv
verilog/decodeCtrl.sv
verilog/decodeStage.sv
testbench/clkGen.sv
testbench/decodeStageTb.sv
